/* hdl/rob_pkg.sv */
package rob_pkg;

    // ********************
    // Sizes
    // ********************
    localparam int ROB_ENTRIES = 7;
    localparam int ROB_FULL_AT = 6; // One slot stays free for the request in flight.

    typedef logic [2:0] rob_tag_t; // Tag 0 means no entry.

    typedef enum logic [4:0] {
        OP_ADD   = 5'b00000,
        OP_AND   = 5'b00001,
        OP_OR    = 5'b00010,
        OP_SLL   = 5'b00011,
        OP_SRL   = 5'b00100,
        OP_SLT   = 5'b00101,
        OP_SLTU  = 5'b00110,
        OP_SRA   = 5'b00111,
        OP_SUB   = 5'b01000,
        OP_XOR   = 5'b01001,
        OP_BEQ   = 5'b01010,
        OP_BGE   = 5'b01011,
        OP_BNE   = 5'b01100,
        OP_BGEU  = 5'b01101,
        OP_LUI   = 5'b01110,
        OP_AUIPC = 5'b01111,
        OP_JAL   = 5'b10000,
        OP_JALR  = 5'b10001,
        OP_LB    = 5'b10010,
        OP_LH    = 5'b10011,
        OP_LW    = 5'b10100,
        OP_LBU   = 5'b10101,
        OP_LHU   = 5'b10110,
        OP_SB    = 5'b10111,
        OP_SH    = 5'b11000,
        OP_SW    = 5'b11001,
        OP_BLT   = 5'b11010,
        OP_BLTU  = 5'b11011,
        OP_NOP   = 5'b11111
    } rob_op_e;

    typedef enum logic [1:0] {
        EXECUTING = 2'b00,
        LS_READY  = 2'b01,
        NOT_TAKEN = 2'b10,
        DONE      = 2'b11
    } rob_state_e;

    typedef enum logic [1:0] {
        SEQ    = 2'b00,
        BRANCH = 2'b01,
        JALR   = 2'b10
    } redirect_kind_e;

    // ********************
    // Shared structs
    // ********************
    typedef struct packed {
        rob_op_e     op;
        logic [4:0]  rd;
        logic        has_imm;
        logic [31:0] imm;
        logic [31:0] pc;
    } dispatch_req_t;

    typedef struct packed {
        logic        valid;
        rob_op_e     op;
        rob_tag_t    tag;
        logic [31:0] value1;
        rob_tag_t    query1;
        logic [31:0] value2;
        rob_tag_t    query2;
    } rs_issue_t;

    typedef struct packed {
        rob_tag_t    tag;
        logic [31:0] value;
    } wb_t;

    typedef struct packed {
        logic        busy;
        rob_op_e     op;
        logic [4:0]  rd;
        rob_state_e  state;
        logic [31:0] value;
        logic [31:0] pc;
        logic [31:0] target;
    } rob_entry_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        rob_tag_t    tag;
        logic [31:0] value;
    } commit_t;

    typedef struct packed {
        logic           valid;
        redirect_kind_e kind;
        logic [31:0]    pc;
    } redirect_t;

    function automatic logic is_branch(rob_op_e op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BLTU, OP_BGE, OP_BGEU};
    endfunction

endpackage

/* hdl/rob_dispatch.sv */
`timescale 1ns/1ps

module rob_dispatch import rob_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  dispatch_req_t req,
    input  logic [31:0]   value1_rf,
    input  logic [31:0]   value2_rf,
    input  rob_tag_t      query1_rf,
    input  rob_tag_t      query2_rf,
    input  rob_tag_t      alloc_tag,
    output rs_issue_t     issue,
    output logic          alloc,
    output rob_entry_t    alloc_entry
);

    logic          valid_q;
    dispatch_req_t req_q;
    logic [31:0]   value1_q;
    logic [31:0]   value2_q;
    rob_tag_t      query1_q;
    rob_tag_t      query2_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= (req.op != OP_NOP);
        end
    end

    // Operands are captured together with the request.
    always_ff @(posedge clk) begin
        if (req.op != OP_NOP) begin
            req_q    <= req;
            value1_q <= value1_rf;
            value2_q <= value2_rf;
            query1_q <= query1_rf;
            query2_q <= query2_rf;
        end
    end

    assign alloc = valid_q;

    always_comb begin
        issue.valid  = valid_q;
        issue.op     = req_q.op;
        issue.tag    = alloc_tag; // The entry is written at the tail this cycle.
        issue.value1 = value1_q;
        issue.query1 = query1_q;
        issue.value2 = req_q.has_imm ? req_q.imm : value2_q;
        issue.query2 = req_q.has_imm ? '0 : query2_q;
    end

    always_comb begin
        alloc_entry.busy   = 1'b1;
        alloc_entry.op     = req_q.op;
        alloc_entry.rd     = req_q.rd;
        alloc_entry.pc     = req_q.pc;
        alloc_entry.target = req_q.pc + req_q.imm;
        alloc_entry.state  = EXECUTING;
        alloc_entry.value  = '0;
        case (req_q.op)
            OP_LUI: begin
                alloc_entry.state = DONE;
                alloc_entry.value = req_q.imm;
            end
            OP_AUIPC: begin
                alloc_entry.state = DONE;
                alloc_entry.value = req_q.pc + req_q.imm;
            end
            OP_JAL: begin
                alloc_entry.state = DONE;
                alloc_entry.value = req_q.pc + 32'd4; // Link address.
            end
            default: ;
        endcase
    end

endmodule

/* hdl/rob_queue.sv */
`timescale 1ns/1ps

module rob_queue import rob_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       alloc,
    input  rob_entry_t alloc_entry,
    input  wb_t        alu_wb,
    input  wb_t        mem_wb,
    input  rob_tag_t   ls_ready_tag,
    input  logic       retire,
    output rob_tag_t   alloc_tag,
    output rob_entry_t head_entry,
    output rob_tag_t   head_tag,
    output logic       rob_full
);

    rob_entry_t entries [1:ROB_ENTRIES];
    rob_tag_t   head;
    rob_tag_t   tail;
    logic [2:0] count;
    logic [2:0] count_next;

    // Pointers run 1..7 and never take the value 0.
    function automatic rob_tag_t next_tag(rob_tag_t t);
        return (t == rob_tag_t'(ROB_ENTRIES)) ? rob_tag_t'(1) : t + rob_tag_t'(1);
    endfunction

    assign alloc_tag  = tail;
    assign head_tag   = head;
    assign head_entry = entries[head];

    always_comb begin
        count_next = count + {2'b00, alloc} - {2'b00, retire};
    end

    // ********************
    // Pointers and occupancy
    // ********************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head     <= rob_tag_t'(1);
            tail     <= rob_tag_t'(1);
            count    <= '0;
            rob_full <= 1'b0;
        end else begin
            if (alloc) begin
                tail <= next_tag(tail);
            end
            if (retire) begin
                head <= next_tag(head);
            end
            count    <= count_next;
            rob_full <= (count_next >= 3'(ROB_FULL_AT));
        end
    end

    // ********************
    // Entry storage
    // ********************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i <= ROB_ENTRIES; i++) begin
                entries[i].busy <= 1'b0;
            end
        end else begin
            // A later DONE from mem_wb wins over the LS_READY mark.
            if (ls_ready_tag != '0) begin
                entries[ls_ready_tag].state <= LS_READY;
            end

            if (alu_wb.tag != '0) begin
                if (is_branch(entries[alu_wb.tag].op)) begin
                    entries[alu_wb.tag].state <= (alu_wb.value == '0) ? NOT_TAKEN : DONE;
                end else if (entries[alu_wb.tag].op == OP_JALR) begin
                    entries[alu_wb.tag].target <= alu_wb.value; // Computed jump address.
                    entries[alu_wb.tag].state  <= DONE;
                end else begin
                    entries[alu_wb.tag].value <= alu_wb.value;
                    entries[alu_wb.tag].state <= DONE;
                end
            end

            if (mem_wb.tag != '0) begin
                entries[mem_wb.tag].value <= mem_wb.value;
                entries[mem_wb.tag].state <= DONE;
            end

            if (alloc) begin
                entries[tail] <= alloc_entry;
            end

            if (retire) begin
                entries[head].busy <= 1'b0;
            end
        end
    end

endmodule

/* hdl/rob_retire.sv */
`timescale 1ns/1ps

module rob_retire import rob_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  rob_entry_t head_entry,
    input  rob_tag_t   head_tag,
    output logic       retire,
    output commit_t    commit,
    output redirect_t  redirect,
    output logic       ls_commit,
    output rob_tag_t   ls_tag
);

    commit_t   commit_d;
    redirect_t redirect_d;
    logic      ls_commit_d;
    logic [31:0] pc_plus4;

    assign pc_plus4 = head_entry.pc + 32'd4;

    assign retire = head_entry.busy &&
                    (head_entry.state == DONE || head_entry.state == NOT_TAKEN);

    assign ls_commit_d = head_entry.busy && (head_entry.state == LS_READY);

    // ********************
    // Head decode
    // ********************
    always_comb begin
        commit_d   = '0;
        redirect_d = '0;
        if (retire) begin
            commit_d.tag     = head_tag;
            redirect_d.valid = 1'b1;
            redirect_d.kind  = SEQ;
            redirect_d.pc    = pc_plus4;
            if (head_entry.state == NOT_TAKEN) begin
                commit_d.valid  = 1'b1; // Empty commit so the front end sees the branch retire.
                redirect_d.kind = BRANCH;
            end else begin
                commit_d.valid = (head_entry.rd != '0);
                commit_d.rd    = head_entry.rd;
                commit_d.value = head_entry.value;
                if (is_branch(head_entry.op)) begin
                    redirect_d.kind = BRANCH;
                    redirect_d.pc   = head_entry.target;
                end else if (head_entry.op == OP_JALR) begin
                    redirect_d.kind = JALR;
                    redirect_d.pc   = head_entry.target;
                    commit_d.value  = pc_plus4;
                end else if (head_entry.op == OP_JAL) begin
                    redirect_d.pc = head_entry.target;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit    <= '0;
            redirect  <= '0;
            ls_commit <= 1'b0;
            ls_tag    <= '0;
        end else begin
            commit    <= commit_d;
            redirect  <= redirect_d;
            ls_commit <= ls_commit_d; // Held while the head waits on memory.
            ls_tag    <= head_tag;
        end
    end

endmodule

/* hdl/rob_top.sv */
`timescale 1ns/1ps

module rob_top import rob_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  dispatch_req_t req,
    input  logic [31:0]   value1_rf,
    input  logic [31:0]   value2_rf,
    input  rob_tag_t      query1_rf,
    input  rob_tag_t      query2_rf,
    input  wb_t           alu_wb,
    input  wb_t           mem_wb,
    input  rob_tag_t      ls_ready_tag,
    output rs_issue_t     issue,
    output logic          rob_full,
    output commit_t       commit,
    output redirect_t     redirect,
    output logic          ls_commit,
    output rob_tag_t      ls_tag
);

    logic       alloc;
    rob_entry_t alloc_entry;
    rob_tag_t   alloc_tag;
    rob_entry_t head_entry;
    rob_tag_t   head_tag;
    logic       retire;

    rob_dispatch u_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .value1_rf   (value1_rf),
        .value2_rf   (value2_rf),
        .query1_rf   (query1_rf),
        .query2_rf   (query2_rf),
        .alloc_tag   (alloc_tag),
        .issue       (issue),
        .alloc       (alloc),
        .alloc_entry (alloc_entry)
    );

    rob_queue u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .alloc_entry  (alloc_entry),
        .alu_wb       (alu_wb),
        .mem_wb       (mem_wb),
        .ls_ready_tag (ls_ready_tag),
        .retire       (retire),
        .alloc_tag    (alloc_tag),
        .head_entry   (head_entry),
        .head_tag     (head_tag),
        .rob_full     (rob_full)
    );

    rob_retire u_retire (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_entry (head_entry),
        .head_tag   (head_tag),
        .retire     (retire),
        .commit     (commit),
        .redirect   (redirect),
        .ls_commit  (ls_commit),
        .ls_tag     (ls_tag)
    );

endmodule

/* dv/rob_props.sv */
`timescale 1ns/1ps

module rob_props import rob_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input rs_issue_t issue,
    input logic      rob_full,
    input commit_t   commit,
    input redirect_t redirect,
    input logic      ls_commit
);

    // A head that waits on memory has not retired yet.
    commit_ls_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(commit.valid && ls_commit))
        else $error("commit.valid and ls_commit are high in the same cycle");

    commit_has_tag: assert property (@(posedge clk) disable iff (!rst_n)
        commit.valid |-> (commit.tag != 3'd0))
        else $error("valid commit carries tag 0");

    // The first cycle out of reset still shows the reset values.
    idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !issue.valid && !commit.valid && !redirect.valid &&
                         !ls_commit && !rob_full)
        else $error("control outputs not idle after reset");

endmodule

bind rob_top rob_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue     (issue),
    .rob_full  (rob_full),
    .commit    (commit),
    .redirect  (redirect),
    .ls_commit (ls_commit)
);

/* dv/tb_rob_top.sv */
`timescale 1ns/1ps

module tb_rob_top import rob_pkg::*; ();

    logic          clk;
    logic          rst_n;
    dispatch_req_t req;
    logic [31:0]   value1_rf;
    logic [31:0]   value2_rf;
    rob_tag_t      query1_rf;
    rob_tag_t      query2_rf;
    wb_t           alu_wb;
    wb_t           mem_wb;
    rob_tag_t      ls_ready_tag;
    rs_issue_t     issue;
    logic          rob_full;
    commit_t       commit;
    redirect_t     redirect;
    logic          ls_commit;
    rob_tag_t      ls_tag;

    int       seed = 2;
    int       errors = 0;
    int       checks = 0;
    int       tests_run = 0;
    rob_tag_t tail_tag = 3'd1; // Tag the next dispatch should receive.
    rob_tag_t last_tag;

    rob_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .value1_rf    (value1_rf),
        .value2_rf    (value2_rf),
        .query1_rf    (query1_rf),
        .query2_rf    (query2_rf),
        .alu_wb       (alu_wb),
        .mem_wb       (mem_wb),
        .ls_ready_tag (ls_ready_tag),
        .issue        (issue),
        .rob_full     (rob_full),
        .commit       (commit),
        .redirect     (redirect),
        .ls_commit    (ls_commit),
        .ls_tag       (ls_tag)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        // Reset plus six tests at up to 200 cycles each.
        repeat (16 + 6 * 200) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

    // ********************
    // Checking and model
    // ********************
    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, expected);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        $display("%s: %s", name, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    // Expected commit and redirect for one retiring instruction.
    task automatic predict(input rob_op_e op, input logic [4:0] rd, input logic [31:0] pc,
                           input logic [31:0] imm, input logic [31:0] result,
                           output logic c_valid, output logic [4:0] c_rd,
                           output logic [31:0] c_value, output redirect_kind_e kind,
                           output logic [31:0] target);
        c_valid = (rd != 5'd0);
        c_rd    = rd;
        c_value = result;
        kind    = SEQ;
        target  = pc + 32'd4;
        case (op)
            OP_LUI:   c_value = imm;
            OP_AUIPC: c_value = pc + imm;
            OP_JAL: begin
                c_value = pc + 32'd4;
                target  = pc + imm;
            end
            OP_JALR: begin
                c_value = pc + 32'd4;
                kind    = JALR;
                target  = result;
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                kind = BRANCH;
                if (result != 32'd0) begin
                    target = pc + imm;
                end else begin
                    c_valid = 1'b1; // Not taken still shows an empty commit.
                    c_rd    = 5'd0;
                    c_value = 32'd0;
                end
            end
            default: ;
        endcase
    endtask

    // ********************
    // Drivers
    // ********************
    task automatic send_req(input rob_op_e op, input logic [4:0] rd, input logic has_imm,
                            input logic [31:0] imm, input logic [31:0] pc);
        logic [31:0] v1;
        logic [31:0] v2;
        rob_tag_t    q1;
        rob_tag_t    q2;
        v1 = $random(seed);
        v2 = $random(seed);
        q1 = rob_tag_t'($random(seed));
        q2 = rob_tag_t'($random(seed));
        @(negedge clk);
        req.op      = op;
        req.rd      = rd;
        req.has_imm = has_imm;
        req.imm     = imm;
        req.pc      = pc;
        value1_rf   = v1;
        value2_rf   = v2;
        query1_rf   = q1;
        query2_rf   = q2;
        @(negedge clk);
        req.op = OP_NOP;
        check("issue.valid", 32'(issue.valid), 32'd1);
        check("issue.tag", 32'(issue.tag), 32'(tail_tag));
        check("issue.op", 32'(issue.op), 32'(op));
        check("issue.value1", issue.value1, v1);
        check("issue.query1", 32'(issue.query1), 32'(q1));
        check("issue.value2", issue.value2, has_imm ? imm : v2);
        check("issue.query2", 32'(issue.query2), has_imm ? 32'd0 : 32'(q2));
        last_tag = tail_tag;
        tail_tag = (tail_tag == 3'd7) ? 3'd1 : tail_tag + 3'd1; // Tag 0 is skipped.
    endtask

    task automatic send_alu(input rob_tag_t tag, input logic [31:0] value);
        @(negedge clk);
        alu_wb.tag   = tag;
        alu_wb.value = value;
        @(negedge clk);
        alu_wb = '0;
    endtask

    task automatic send_mem(input rob_tag_t tag, input logic [31:0] value);
        @(negedge clk);
        mem_wb.tag   = tag;
        mem_wb.value = value;
        @(negedge clk);
        mem_wb = '0;
    endtask

    task automatic mark_ls(input rob_tag_t tag);
        @(negedge clk);
        ls_ready_tag = tag;
        @(negedge clk);
        ls_ready_tag = '0;
    endtask

    // Every retirement raises redirect.valid, so it marks the commit cycle.
    task automatic wait_retire(output commit_t c, output redirect_t r);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!redirect.valid && cycles < 50);
        if (!redirect.valid) begin
            $display("No retirement seen within 50 cycles");
            errors++;
        end
        c = commit;
        r = redirect;
    endtask

    task automatic expect_retire(input rob_tag_t tag, input rob_op_e op, input logic [4:0] rd,
                                 input logic [31:0] pc, input logic [31:0] imm,
                                 input logic [31:0] result);
        commit_t        c;
        redirect_t      r;
        logic           c_valid;
        logic [4:0]     c_rd;
        logic [31:0]    c_value;
        redirect_kind_e kind;
        logic [31:0]    target;
        wait_retire(c, r);
        predict(op, rd, pc, imm, result, c_valid, c_rd, c_value, kind, target);
        check("commit.valid", 32'(c.valid), 32'(c_valid));
        if (c_valid) begin
            check("commit.rd", 32'(c.rd), 32'(c_rd));
            check("commit.tag", 32'(c.tag), 32'(tag));
            check("commit.value", c.value, c_value);
        end
        check("redirect.kind", 32'(r.kind), 32'(kind));
        check("redirect.pc", r.pc, target);
    endtask

    // ********************
    // Directed tests
    // ********************
    task automatic reset_outputs_idle();
        int e0;
        e0 = errors;
        @(negedge clk);
        check("issue.valid", 32'(issue.valid), 32'd0);
        check("commit.valid", 32'(commit.valid), 32'd0);
        check("redirect.valid", 32'(redirect.valid), 32'd0);
        check("ls_commit", 32'(ls_commit), 32'd0);
        check("rob_full", 32'(rob_full), 32'd0);
        end_test("reset", e0);
    endtask

    task automatic add_with_immediate();
        int          e0;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] result;
        e0     = errors;
        pc     = $random(seed) & 32'hffff_fffc;
        imm    = $random(seed);
        result = $random(seed);
        send_req(OP_ADD, 5'd5, 1'b1, imm, pc);
        send_alu(last_tag, result);
        expect_retire(last_tag, OP_ADD, 5'd5, pc, imm, result);
        end_test("add_imm", e0);
    endtask

    task automatic upper_and_jal();
        int          e0;
        rob_op_e     ops [3];
        logic [31:0] pc;
        logic [31:0] imm;
        e0     = errors;
        ops[0] = OP_LUI;
        ops[1] = OP_AUIPC;
        ops[2] = OP_JAL;
        for (int i = 0; i < 3; i++) begin
            pc  = $random(seed) & 32'hffff_fffc;
            imm = $random(seed);
            send_req(ops[i], 5'(i + 1), 1'b1, imm, pc);
            expect_retire(last_tag, ops[i], 5'(i + 1), pc, imm, 32'd0);
        end
        end_test("upper_jumps", e0);
    endtask

    task automatic reverse_results_and_full();
        int          e0;
        rob_tag_t    tags [6];
        logic [31:0] pcs [6];
        logic [31:0] imms [6];
        logic [31:0] results [6];
        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            pcs[i]     = $random(seed) & 32'hffff_fffc;
            imms[i]    = $random(seed);
            results[i] = $random(seed);
            send_req(OP_XOR, 5'(i + 1), 1'b0, imms[i], pcs[i]);
            tags[i] = last_tag;
        end
        @(negedge clk);
        check("rob_full", 32'(rob_full), 32'd1);
        for (int i = 5; i >= 0; i--) begin
            send_alu(tags[i], results[i]);
        end
        for (int i = 0; i < 6; i++) begin
            expect_retire(tags[i], OP_XOR, 5'(i + 1), pcs[i], imms[i], results[i]);
        end
        check("rob_full", 32'(rob_full), 32'd0);
        end_test("reverse_full", e0);
    endtask

    task automatic branches_and_jalr();
        int          e0;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] target;
        e0  = errors;
        pc  = $random(seed) & 32'hffff_fffc;
        imm = $random(seed) & 32'hffff_fffc;
        send_req(OP_BEQ, 5'd0, 1'b0, imm, pc);
        send_alu(last_tag, 32'd1);
        expect_retire(last_tag, OP_BEQ, 5'd0, pc, imm, 32'd1);
        pc  = $random(seed) & 32'hffff_fffc;
        imm = $random(seed) & 32'hffff_fffc;
        send_req(OP_BNE, 5'd0, 1'b0, imm, pc);
        send_alu(last_tag, 32'd0);
        expect_retire(last_tag, OP_BNE, 5'd0, pc, imm, 32'd0);
        pc     = $random(seed) & 32'hffff_fffc;
        imm    = $random(seed);
        target = $random(seed) & 32'hffff_fffe;
        send_req(OP_JALR, 5'd1, 1'b1, imm, pc);
        send_alu(last_tag, target);
        expect_retire(last_tag, OP_JALR, 5'd1, pc, imm, target);
        end_test("branches", e0);
    endtask

    task automatic store_waits_on_memory();
        int          e0;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] data;
        rob_tag_t    t;
        e0   = errors;
        pc   = $random(seed) & 32'hffff_fffc;
        imm  = $random(seed);
        data = $random(seed);
        send_req(OP_SW, 5'd0, 1'b0, imm, pc);
        t = last_tag;
        mark_ls(t);
        repeat (3) begin
            @(negedge clk);
            check("ls_commit", 32'(ls_commit), 32'd1);
            check("ls_tag", 32'(ls_tag), 32'(t));
        end
        send_mem(t, data);
        expect_retire(t, OP_SW, 5'd0, pc, imm, data);
        check("ls_commit", 32'(ls_commit), 32'd0);
        end_test("store", e0);
    endtask

    initial begin
        rst_n        = 1'b0;
        req          = '0;
        req.op       = OP_NOP;
        value1_rf    = '0;
        value2_rf    = '0;
        query1_rf    = '0;
        query2_rf    = '0;
        alu_wb       = '0;
        mem_wb       = '0;
        ls_ready_tag = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        reset_outputs_idle();
        add_with_immediate();
        upper_and_jal();
        reverse_results_and_full();
        branches_and_jalr();
        store_waits_on_memory();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* filelist.f */
hdl/rob_pkg.sv
hdl/rob_dispatch.sv
hdl/rob_queue.sv
hdl/rob_retire.sv
hdl/rob_top.sv
dv/rob_props.sv
dv/tb_rob_top.sv

/* Makefile */
TOP = tb_rob_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
